//--- tb.f
src/mipsIsaPkg.sv
src/predictorPkg.sv
src/branchDecoder.sv
src/historyTable.sv
src/patternTable.sv
src/predictCtrl.sv
src/branchPredictTop.sv
test/branchPredict_chk.sv
test/tbBranchPredict.sv

//--- Bender.yml
package:
  name: branch_predict

sources:
  - src/mipsIsaPkg.sv
  - src/predictorPkg.sv
  - src/branchDecoder.sv
  - src/historyTable.sv
  - src/patternTable.sv
  - src/predictCtrl.sv
  - src/branchPredictTop.sv
  - target: test
    files:
      - test/branchPredict_chk.sv
      - test/tbBranchPredict.sv

//--- test/tbBranchPredict.sv
`timescale 1ns/1ps

module tbBranchPredict;
    import mipsIsaPkg::*;
    import predictorPkg::*;

    localparam int histBits   = defaultHistBits;
    localparam int indexBits  = defaultIndexBits;
    localparam int queueDepth = defaultQueueDepth;

    logic        clk;
    logic        rst;
    instrWord    instr;
    logic [31:0] pc;
    logic        isBranch;
    logic        isJump;
    logic [31:0] target;
    logic        predTake;
    logic        updValid;
    logic [31:0] updPc;
    logic        updTaken;
    logic        hold;
    logic        creditReturn;

    // Reference tables, counter level 0 is strongly not taken and 3 strongly taken
    logic [histBits-1:0] modelHist [2**indexBits];
    int                  modelLevel [2**histBits];
    // Pending updates as {taken, index}, oldest first
    logic [indexBits:0]  modelQueue [$];

    int          seed;
    logic        resetReq;
    int          credits;
    logic        stall;
    logic [31:0] pcPool [6];

    branchPredictTop u_dut (
        .clk          (clk),
        .rst          (rst),
        .instr        (instr),
        .pc           (pc),
        .isBranch     (isBranch),
        .isJump       (isJump),
        .target       (target),
        .predTake     (predTake),
        .updValid     (updValid),
        .updPc        (updPc),
        .updTaken     (updTaken),
        .hold         (hold),
        .creditReturn (creditReturn)
    );

    always #20 clk = ~clk;

    // --------------------
    // Failure reporting
    // --------------------

    task automatic endWithFail();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic valueMismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
        endWithFail();
    endtask

    task automatic drainTimeout(input int limit);
        $display("Timeout: the update queue did not drain within %0d cycles", limit);
        endWithFail();
    endtask

    // --------------------
    // Reference model
    // --------------------

    function automatic int stepLevel(input int level, input logic taken);
        if (taken) begin
            return (level == 3) ? 3 : level + 1;
        end
        return (level == 0) ? 0 : level - 1;
    endfunction

    function automatic void decodeModel(input logic [31:0] w, input logic [31:0] addr,
                                        output logic br, output logic jmp,
                                        output logic [31:0] tgt);
        logic [31:0] next;
        next = addr + 32'd4;
        br   = ((w[31:26] == opRegimm) && (w[20:18] == 3'b000))
            || (w[31:26] inside {opBeq, opBne, opBlez, opBgtz});
        jmp  = (w[31:26] == opJ) || (w[31:26] == opJal);
        if (br) begin
            tgt = next + (32'($signed(w[15:0])) << 2);
        end else if (jmp) begin
            tgt = (next & 32'hf000_0000) | {4'b0000, w[25:0], 2'b00};
        end else begin
            tgt = next;
        end
    endfunction

    // Advances the model by one rising edge using the inputs of the cycle that ends there
    task automatic applyEdge();
        logic [indexBits:0]  entry;
        logic [histBits-1:0] h;
        if (rst) begin
            foreach (modelHist[i]) modelHist[i] = '0;
            foreach (modelLevel[i]) modelLevel[i] = 2;
            modelQueue.delete();
            credits = queueDepth;
        end else begin
            if (!hold && modelQueue.size() > 0) begin
                entry = modelQueue.pop_front();
                h = modelHist[entry[indexBits-1:0]];
                modelLevel[h] = stepLevel(modelLevel[h], entry[indexBits]);
                modelHist[entry[indexBits-1:0]] = {h[histBits-2:0], entry[indexBits]};
            end
            if (updValid) begin
                modelQueue.push_back({updTaken, updPc[indexBits+1:2]});
            end
        end
    endtask

    task automatic checkOutputs();
        logic        expBranch;
        logic        expJump;
        logic        expTake;
        logic        expReturn;
        logic [31:0] expTarget;
        decodeModel(instr, pc, expBranch, expJump, expTarget);
        expTake   = expBranch && (modelLevel[modelHist[pc[indexBits+1:2]]] >= 2);
        expReturn = !hold && (modelQueue.size() > 0);
        assert (isBranch === expBranch) else valueMismatch("isBranch", expBranch, isBranch);
        assert (isJump === expJump) else valueMismatch("isJump", expJump, isJump);
        assert (target === expTarget) else valueMismatch("target", expTarget, target);
        assert (predTake === expTake) else valueMismatch("predTake", expTake, predTake);
        assert (creditReturn === expReturn)
            else valueMismatch("creditReturn", expReturn, creditReturn);
    endtask

    // --------------------
    // Stimulus
    // --------------------

    task automatic runCycle(input logic [31:0] word, input logic [31:0] addr,
                            input logic wantPush, input logic [31:0] pushPc,
                            input logic pushTaken, input logic stallNow);
        @(posedge clk);
        applyEdge();
        #1;
        rst      = resetReq;
        instr    = word;
        pc       = addr;
        hold     = stallNow;
        updValid = wantPush && (credits > 0);
        updPc    = pushPc;
        updTaken = pushTaken;
        if (updValid) begin
            credits--;
        end
        #5;
        checkOutputs();
        // A returned credit can be spent from the next cycle on
        if (creditReturn) begin
            credits++;
        end
    endtask

    // Every pushed entry has been applied once all credits are back
    task automatic waitDrain(input int limit);
        int waited;
        waited = 0;
        while (credits < queueDepth) begin
            if (waited == limit) begin
                drainTimeout(limit);
            end else begin
                runCycle(32'h0000_0020, 32'h0040_0100, 1'b0, 32'h0, 1'b0, 1'b0);
                waited++;
            end
        end
    endtask

    // Random word with the branch and jump opcodes mixed in
    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        int          sel;
        w   = $random(seed);
        sel = $unsigned($random(seed)) % 10;
        case (sel)
            0: begin
                w[31:26] = opRegimm;
                w[20:18] = 3'b000;
            end
            1: w[31:26] = opRegimm;
            2: w[31:26] = opBeq;
            3: w[31:26] = opBne;
            4: w[31:26] = opBlez;
            5: w[31:26] = opBgtz;
            6: w[31:26] = opJ;
            7: w[31:26] = opJal;
            default: ;
        endcase
        return w;
    endfunction

    initial begin
        seed     = 32'ha9e52d72;
        clk      = 1'b0;
        rst      = 1'b1;
        resetReq = 1'b1;
        instr    = '0;
        pc       = '0;
        updValid = 1'b0;
        updPc    = '0;
        updTaken = 1'b0;
        hold     = 1'b0;
        stall    = 1'b0;
        credits  = queueDepth;
        // Pairs 0/2, 1/3 and 4/5 share pc bits 11 to 2
        pcPool[0] = 32'h0040_1000;
        pcPool[1] = 32'h0040_1008;
        pcPool[2] = 32'h0040_2000;
        pcPool[3] = 32'h0041_1008;
        pcPool[4] = 32'h0040_1ffc;
        pcPool[5] = 32'h0040_0ffc;

        runCycle(32'h0, 32'h0040_0000, 1'b0, 32'h0, 1'b0, 1'b0);
        resetReq = 1'b0;
        runCycle(32'h0, 32'h0040_0000, 1'b0, 32'h0, 1'b0, 1'b0);

        // Decoding and reset-state predictions
        for (int i = 0; i < 300; i++) begin
            runCycle(randomWord(), {$random(seed)} & 32'hffff_fffc, 1'b0, 32'h0, 1'b0,
                     $random(seed));
        end

        // Train one branch down to strongly not taken, then back up
        for (int i = 0; i < 48; i++) begin
            runCycle({opBeq, 5'd3, 5'd4, 16'hfff0}, pcPool[0], 1'b1, pcPool[0], i >= 24, 1'b0);
        end
        waitDrain(16);

        // Spend every credit while stalled, the extra pushes must be held back
        for (int i = 0; i < queueDepth + 2; i++) begin
            runCycle(32'h0000_0020, pcPool[1], 1'b1, pcPool[i % 6], (i % 2) == 1, 1'b1);
        end
        waitDrain(16);

        // Random hold periods with aliased pcs on both sides
        for (int i = 0; i < 500; i++) begin
            if (($random(seed) & 7) == 0) begin
                stall = ~stall;
            end
            runCycle({opBne, 10'($random(seed)), 16'($random(seed))},
                     pcPool[$unsigned($random(seed)) % 6], 1'b1,
                     pcPool[$unsigned($random(seed)) % 6], $random(seed), stall);
        end
        waitDrain(16);

        if (u_dut.u_chk.failCount != 0) begin
            $display("The bound checker saw %0d assertion failures", u_dut.u_chk.failCount);
            endWithFail();
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

//--- test/branchPredict_chk.sv
`timescale 1ns/1ps

module branchPredictChk #(
    parameter int QUEUE_DEPTH = 4
) (
    input logic clk,
    input logic rst,
    input logic updValid,
    input logic hold,
    input logic creditReturn
);

    // Updates pushed and not yet applied, which is also the queue fill
    int inFlight;

    // Number of assertion failures seen so far
    int failCount = 0;

    always_ff @(posedge clk) begin
        if (rst) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + int'(updValid) - int'(creditReturn);
        end
    end

    resetQuiet: assert property (@(posedge clk) rst |=> !creditReturn)
        else begin
            $error("creditReturn high in the cycle after reset");
            failCount++;
        end

    noPushWhenFull: assert property (@(posedge clk) disable iff (rst)
        !(updValid && inFlight == QUEUE_DEPTH))
        else begin
            $error("Update pushed into a full queue");
            failCount++;
        end

    noReturnOnHold: assert property (@(posedge clk) disable iff (rst) hold |-> !creditReturn)
        else begin
            $error("creditReturn while hold is high");
            failCount++;
        end

    creditBound: assert property (@(posedge clk) disable iff (rst) inFlight <= QUEUE_DEPTH)
        else begin
            $error("More credits in flight than the queue depth");
            failCount++;
        end

endmodule

bind branchPredictTop branchPredictChk #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
) u_chk (
    .clk          (clk),
    .rst          (rst),
    .updValid     (updValid),
    .hold         (hold),
    .creditReturn (creditReturn)
);

//--- src/branchPredictTop.sv
`timescale 1ns/1ps

module branchPredictTop #(
    parameter int HIST_BITS   = predictorPkg::defaultHistBits,
    parameter int INDEX_BITS  = predictorPkg::defaultIndexBits,
    parameter int QUEUE_DEPTH = predictorPkg::defaultQueueDepth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  mipsIsaPkg::instrWord instr,
    input  logic [31:0]          pc,
    output logic                 isBranch,
    output logic                 isJump,
    output logic [31:0]          target,
    output logic                 predTake,
    input  logic                 updValid,
    input  logic [31:0]          updPc,
    input  logic                 updTaken,
    input  logic                 hold,
    output logic                 creditReturn
);
    import predictorPkg::*;

    logic [HIST_BITS-1:0]  predHistory;
    counterState           predCounter;
    logic                  wrEn;
    logic [INDEX_BITS-1:0] wrIndex;
    logic                  wrTaken;
    logic [HIST_BITS-1:0]  wrHistory;
    logic                  cntEn;
    logic                  cntTaken;

    // --------------------
    // Decode stage
    // --------------------

    branchDecoder u_decoder (
        .instr    (instr),
        .pc       (pc),
        .isBranch (isBranch),
        .isJump   (isJump),
        .target   (target)
    );

    // --------------------
    // Tables
    // --------------------

    historyTable #(
        .HIST_BITS  (HIST_BITS),
        .INDEX_BITS (INDEX_BITS)
    ) u_history (
        .clk       (clk),
        .rst       (rst),
        .rdIndex   (pc[INDEX_BITS+1:2]),
        .rdHistory (predHistory),
        .wrIndex   (wrIndex),
        .wrHistory (wrHistory),
        .wrEn      (wrEn),
        .wrTaken   (wrTaken)
    );

    // The update counter is selected by the history before the shift
    patternTable #(
        .HIST_BITS (HIST_BITS)
    ) u_pattern (
        .clk       (clk),
        .rst       (rst),
        .rdIndex   (predHistory),
        .rdCounter (predCounter),
        .cntIndex  (wrHistory),
        .cntEn     (cntEn),
        .cntTaken  (cntTaken)
    );

    // --------------------
    // Control
    // --------------------

    predictCtrl #(
        .INDEX_BITS  (INDEX_BITS),
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .isBranch     (isBranch),
        .predCounter  (predCounter),
        .predTake     (predTake),
        .updValid     (updValid),
        .updPc        (updPc),
        .updTaken     (updTaken),
        .hold         (hold),
        .creditReturn (creditReturn),
        .wrEn         (wrEn),
        .wrIndex      (wrIndex),
        .wrTaken      (wrTaken),
        .cntEn        (cntEn),
        .cntTaken     (cntTaken)
    );

endmodule

//--- src/predictCtrl.sv
`timescale 1ns/1ps

module predictCtrl #(
    parameter int INDEX_BITS  = 10,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      isBranch,
    input  predictorPkg::counterState predCounter,
    output logic                      predTake,
    input  logic                      updValid,
    input  logic [31:0]               updPc,
    input  logic                      updTaken,
    input  logic                      hold,
    output logic                      creditReturn,
    output logic                      wrEn,
    output logic [INDEX_BITS-1:0]     wrIndex,
    output logic                      wrTaken,
    output logic                      cntEn,
    output logic                      cntTaken
);

    localparam int ptrBits = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int countBits = $clog2(QUEUE_DEPTH + 1);
    localparam logic [ptrBits-1:0] lastSlot = ptrBits'(QUEUE_DEPTH - 1);

    // Queue payload, one history index and one outcome per entry
    logic [INDEX_BITS-1:0] queueIndex [QUEUE_DEPTH];
    logic                  queueTaken [QUEUE_DEPTH];

    logic [ptrBits-1:0]   headPtr;
    logic [ptrBits-1:0]   tailPtr;
    logic [countBits-1:0] entryCount;
    logic                 push;
    logic                 pop;

    function automatic logic [ptrBits-1:0] nextSlot(input logic [ptrBits-1:0] slot);
        return (slot == lastSlot) ? '0 : slot + 1'b1;
    endfunction

    // --------------------
    // Decode side
    // --------------------

    // Bit 1 of the counter is the taken direction
    assign predTake = isBranch & predCounter[1];

    // --------------------
    // Update queue
    // --------------------

    // The sender only pushes while it holds a credit, so the queue has room
    assign push = updValid;

    // Oldest entry goes out whenever the pipeline is not stalled
    assign pop = (entryCount != '0) && !hold;

    always_ff @(posedge clk) begin
        if (push) begin
            queueIndex[tailPtr] <= updPc[INDEX_BITS+1:2];
            queueTaken[tailPtr] <= updTaken;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            headPtr    <= '0;
            tailPtr    <= '0;
            entryCount <= '0;
        end else begin
            if (push) begin
                tailPtr <= nextSlot(tailPtr);
            end
            if (pop) begin
                headPtr <= nextSlot(headPtr);
            end
            case ({push, pop})
                2'b10:   entryCount <= entryCount + 1'b1;
                2'b01:   entryCount <= entryCount - 1'b1;
                default: entryCount <= entryCount;
            endcase
        end
    end

    // --------------------
    // Table writes
    // --------------------

    // Both tables and the credit return all follow the same pop
    assign wrEn         = pop;
    assign cntEn        = pop;
    assign creditReturn = pop;

    assign wrIndex  = queueIndex[headPtr];
    assign wrTaken  = queueTaken[headPtr];
    assign cntTaken = queueTaken[headPtr];

endmodule

//--- src/patternTable.sv
`timescale 1ns/1ps

module patternTable #(
    parameter int HIST_BITS = 6
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [HIST_BITS-1:0]     rdIndex,
    output predictorPkg::counterState rdCounter,
    input  logic [HIST_BITS-1:0]     cntIndex,
    input  logic                     cntEn,
    input  logic                     cntTaken
);
    import predictorPkg::*;

    localparam int entries = 2 ** HIST_BITS;

    counterState counters [entries];
    counterState current;
    counterState stepped;

    // Prediction port
    assign rdCounter = counters[rdIndex];

    // --------------------
    // Counter training
    // --------------------

    assign current = counters[cntIndex];

    // One step towards the resolved direction, held at either end
    always_comb begin
        stepped = current;
        unique case (current)
            strongNotTaken: begin
                stepped = cntTaken ? weakNotTaken : strongNotTaken;
            end
            weakNotTaken: begin
                stepped = cntTaken ? weakTaken : strongNotTaken;
            end
            weakTaken: begin
                stepped = cntTaken ? strongTaken : weakNotTaken;
            end
            strongTaken: begin
                stepped = cntTaken ? strongTaken : weakTaken;
            end
        endcase
    end

    // Counters only move on a real update, idle cycles leave them alone
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                counters[i] <= counterResetState;
            end
        end else if (cntEn) begin
            counters[cntIndex] <= stepped;
        end
    end

endmodule

//--- src/historyTable.sv
`timescale 1ns/1ps

module historyTable #(
    parameter int HIST_BITS  = 6,
    parameter int INDEX_BITS = 10
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [INDEX_BITS-1:0] rdIndex,
    output logic [HIST_BITS-1:0]  rdHistory,
    input  logic [INDEX_BITS-1:0] wrIndex,
    output logic [HIST_BITS-1:0]  wrHistory,
    input  logic                  wrEn,
    input  logic                  wrTaken
);

    localparam int entries = 2 ** INDEX_BITS;

    // One shift register per branch slot, newest outcome in bit 0
    logic [HIST_BITS-1:0] history [entries];

    // --------------------
    // Read ports
    // --------------------

    // Decode-side lookup for the prediction
    assign rdHistory = history[rdIndex];

    // Update-side lookup, the pattern table trains the counter this selects
    assign wrHistory = history[wrIndex];

    // --------------------
    // Write port
    // --------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                history[i] <= '0;
            end
        end else if (wrEn) begin
            // Oldest outcome falls off the top
            history[wrIndex] <= {wrHistory[HIST_BITS-2:0], wrTaken};
        end
    end

endmodule

//--- src/branchDecoder.sv
`timescale 1ns/1ps

module branchDecoder (
    input  mipsIsaPkg::instrWord instr,
    input  logic [31:0]          pc,
    output logic                 isBranch,
    output logic                 isJump,
    output logic [31:0]          target
);
    import mipsIsaPkg::*;

    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        regimmBranch;
    logic        plainBranch;

    assign pcPlus4 = pc + 32'd4;

    // --------------------
    // Conditional branches
    // --------------------

    // bltz and bgez live under REGIMM with rt bits 4 to 2 clear
    assign regimmBranch = (instr.iView.opcode == opRegimm) && (instr.iView.rt[4:2] == 3'b000);

    assign plainBranch = instr.iView.opcode inside {opBeq, opBne, opBlez, opBgtz};

    assign isBranch = regimmBranch || plainBranch;

    // Word offset, sign extended and turned into a byte offset
    assign branchOffset = {{14{instr.iView.offset[15]}}, instr.iView.offset, 2'b00};
    assign branchTarget = pcPlus4 + branchOffset;

    // --------------------
    // Jumps
    // --------------------

    assign isJump = instr.jView.opcode inside {opJ, opJal};

    // The jump stays inside the 256 MB region of the delay slot
    assign jumpTarget = {pcPlus4[31:28], instr.jView.index, 2'b00};

    always_comb begin
        if (isBranch) begin
            target = branchTarget;
        end else if (isJump) begin
            target = jumpTarget;
        end else begin
            target = pcPlus4;
        end
    end

endmodule

//--- src/predictorPkg.sv
package predictorPkg;

    // Two-bit saturating counter
    // Bit 1 alone gives the predicted direction, so the encoding is Gray-like
    typedef enum logic [1:0] {
        strongNotTaken = 2'b00,
        weakNotTaken   = 2'b01,
        weakTaken      = 2'b11,
        strongTaken    = 2'b10
    } counterState;

    // Every counter starts out leaning towards taken
    localparam counterState counterResetState = weakTaken;

    // --------------------
    // Default table geometry
    // --------------------

    // History length per branch, which is also the pattern table index width
    localparam int defaultHistBits = 6;

    // History table index width, taken from pc bits 11 to 2
    localparam int defaultIndexBits = 10;

    // Number of update credits held by the memory stage after reset
    localparam int defaultQueueDepth = 4;

endpackage

//--- src/mipsIsaPkg.sv
package mipsIsaPkg;

    typedef logic [5:0] opcodeField;
    typedef logic [4:0] regField;

    // I-type layout as used by the conditional branches
    typedef struct packed {
        opcodeField  opcode;
        regField     rs;
        regField     rt;
        logic [15:0] offset;
    } iFormat;

    // J-type layout as used by j and jal
    typedef struct packed {
        opcodeField  opcode;
        logic [25:0] index;
    } jFormat;

    // One instruction word, readable through either format
    typedef union packed {
        iFormat iView;
        jFormat jView;
    } instrWord;

    // --------------------
    // Opcodes of the branch and jump classes
    // --------------------

    // REGIMM carries bltz and bgez in the rt field
    localparam opcodeField opRegimm = 6'b000001;
    localparam opcodeField opJ      = 6'b000010;
    localparam opcodeField opJal    = 6'b000011;
    localparam opcodeField opBeq    = 6'b000100;
    localparam opcodeField opBne    = 6'b000101;
    localparam opcodeField opBlez   = 6'b000110;
    localparam opcodeField opBgtz   = 6'b000111;

endpackage
